/* list.f */
+incdir+hdl
hdl/spi_frame_pkg.sv
hdl/hk_regmap_pkg.sv
hdl/spi_slave.sv
hdl/reg_decode.sv
hdl/ctrl_reg.sv
hdl/readback_sel.sv
hdl/hk_top.sv
tb/tb_hk_top.sv

/* Bender.yml */
package:
  name: hk_top

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/spi_frame_pkg.sv
      - hdl/hk_regmap_pkg.sv
      - hdl/spi_slave.sv
      - hdl/reg_decode.sv
      - hdl/ctrl_reg.sv
      - hdl/readback_sel.sv
      - hdl/hk_top.sv
      - target: test
        files:
          - tb/tb_hk_top.sv

/* tb/tb_hk_top.sv */
// housekeeping block testbench
// bit-bangs spi frames into hk_top and checks pins and readback words

`timescale 1ns/1ps
`default_nettype none

`include "hk_defines.svh"

module tb_hk_top;

  logic       clk;
  logic       arst_n;
  logic       sck;
  logic       ss;
  logic       sdi;
  logic       sdo;
  logic [2:0] led;
  logic [7:0] mon;
  logic [2:0] hw;

  // expected contents of led, mon, scratch
  logic [`HK_DATA_W-1:0] model [`HK_NUM_CTRL];
  logic [2:0]            hw_model;
  int                    errs;
  int                    pass_count;
  int                    fail_count;
  int unsigned           seed_ret;

  hk_top hk_top_i (
    .clk    (clk),
    .arst_n (arst_n),
    .sck    (sck),
    .ss     (ss),
    .sdi    (sdi),
    .sdo    (sdo),
    .led    (led),
    .mon    (mon),
    .hw     (hw)
  );

  always #4 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////

  // one frame msb first in mode 0 with 4 clk per sck half period
  // sdo captured on rising sck during the data word
  task automatic spi_xfer(input int nbits, input logic [`HK_FRAME_BITS-1:0] frame,
                          output logic [`HK_DATA_W-1:0] rx);
    rx = '0;
    // ss high long enough between frames
    repeat (4) @(posedge clk);
    ss <= 1'b0;
    for (int i = 0; i < nbits; i++) begin
      sdi <= frame[`HK_FRAME_BITS-1-i];
      repeat (4) @(posedge clk);
      sck <= 1'b1;
      if (i >= 8)
        rx = {rx[`HK_DATA_W-2:0], sdo};
      repeat (4) @(posedge clk);
      sck <= 1'b0;
    end
    repeat (4) @(posedge clk);
    ss <= 1'b1;
  endtask

  task automatic check_word(input string name, input logic [`HK_DATA_W-1:0] exp,
                            input logic [`HK_DATA_W-1:0] act);
    if (exp !== act) begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      errs++;
    end
  endtask

  // bit rules of the register map where unknown codes only read
  function automatic logic [`HK_DATA_W-1:0] apply_op(input logic [`HK_DATA_W-1:0] old,
                                                     input logic [3:0] op,
                                                     input logic [`HK_DATA_W-1:0] data);
    case (op)
      4'd1:    return data;
      4'd2:    return old | data;
      4'd3:    return old & ~data;
      4'd4:    return old ^ data;
      default: return old;
    endcase
  endfunction

  // pins must follow the model within 6 cycles of ss going high and then hold
  task automatic wait_pins(input string name);
    int   n;
    logic hit;
    n   = 0;
    hit = 1'b0;
    while (!hit && n < 20) begin
      @(negedge clk);
      n++;
      if (led === model[0][2:0] && mon === model[1][7:0])
        hit = 1'b1;
    end
    if (!hit) begin
      $display("FAILED %s expected led %h mon %h actual led %h mon %h",
               name, model[0][2:0], model[1][7:0], led, mon);
      errs++;
    end else if (n > 6) begin
      $display("%s: led and mon took %0d cycles to update, more than 6", name, n);
      errs++;
    end else begin
      // ride out the update window so a stray late write shows
      while (n < 6) begin
        @(negedge clk);
        n++;
      end
      if (led !== model[0][2:0] || mon !== model[1][7:0]) begin
        $display("FAILED %s expected led %h mon %h actual led %h mon %h",
                 name, model[0][2:0], model[1][7:0], led, mon);
        errs++;
      end
    end
  endtask

  // modifying frame to a control register that checks the old value coming back
  task automatic reg_op(input string name, input logic [3:0] op, input logic [3:0] addr,
                        input logic [`HK_DATA_W-1:0] data);
    logic [`HK_DATA_W-1:0] rx;
    spi_xfer(`HK_FRAME_BITS, {op, addr, data}, rx);
    check_word(name, model[addr], rx);
    model[addr] = apply_op(model[addr], op, data);
    wait_pins(name);
  endtask

  task automatic read_reg(input string name, input logic [3:0] addr,
                          input logic [`HK_DATA_W-1:0] exp);
    logic [`HK_DATA_W-1:0] rx;
    spi_xfer(`HK_FRAME_BITS, {4'd0, addr, 32'h0}, rx);
    check_word(name, exp, rx);
  endtask

  task automatic end_test(input string name);
    if (errs == 0) begin
      pass_count++;
      $display("%s: ok", name);
    end else begin
      fail_count++;
      $display("%s: %0d errors", name, errs);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////

  task automatic test_reset_ident();
    errs = 0;
    @(negedge clk);
    check_word("reset_led", 32'h0, {29'h0, led});
    check_word("reset_mon", 32'h0, {24'h0, mon});
    check_word("reset_sdo", 32'h0, {31'h0, sdo});
    read_reg("ident", 4'd4, `HK_IDENT);
    read_reg("unmapped", 4'd7, 32'h0);
    end_test("reset_ident");
  endtask

  task automatic test_write_readback();
    logic [`HK_DATA_W-1:0] v;
    errs = 0;
    for (int a = 0; a < `HK_NUM_CTRL; a++) begin
      v = $urandom;
      reg_op("write", 4'd1, 4'(a), v);
      read_reg("readback", 4'(a), v);
    end
    end_test("write_readback");
  endtask

  task automatic test_bit_ops();
    logic [3:0] addr;
    errs = 0;
    for (int r = 0; r < 4; r++) begin
      // scratch then led
      addr = (r % 2 == 0) ? 4'd2 : 4'd0;
      reg_op("set", 4'd2, addr, $urandom);
      reg_op("clear", 4'd3, addr, $urandom);
      reg_op("toggle", 4'd4, addr, $urandom);
    end
    read_reg("final_scratch", 4'd2, model[2]);
    read_reg("final_led", 4'd0, model[0]);
    end_test("bit_ops");
  endtask

  task automatic test_hw_status();
    errs = 0;
    for (int r = 0; r < 6; r++) begin
      @(posedge clk);
      hw_model = 3'($urandom);
      hw <= hw_model;
      repeat (5) @(posedge clk);
      read_reg("status", 4'd3, {29'h0, hw_model});
    end
    end_test("hw_status");
  endtask

  task automatic test_malformed();
    logic [`HK_DATA_W-1:0] rx;
    errs = 0;
    // write to scratch cut after 20 bits
    spi_xfer(20, {4'd1, 4'd2, 32'hdead_beef}, rx);
    wait_pins("short_frame");
    // write to the read only status address
    spi_xfer(`HK_FRAME_BITS, {4'd1, 4'd3, 32'hffff_ffff}, rx);
    check_word("status_write", {29'h0, hw_model}, rx);
    wait_pins("status_write");
    for (int a = 0; a < `HK_NUM_CTRL; a++)
      read_reg("unchanged", 4'(a), model[a]);
    read_reg("status_after", 4'd3, {29'h0, hw_model});
    end_test("malformed");
  endtask

  ////////////////////////////////////////////////////////////////////////
  // sequence
  ////////////////////////////////////////////////////////////////////////

  initial begin
    clk        = 1'b0;
    arst_n     = 1'b0;
    sck        = 1'b0;
    ss         = 1'b1;
    sdi        = 1'b0;
    hw         = 3'b000;
    hw_model   = 3'b000;
    pass_count = 0;
    fail_count = 0;
    for (int a = 0; a < `HK_NUM_CTRL; a++)
      model[a] = '0;
    seed_ret = $urandom(32'hb351_4d4a);

    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    repeat (2) @(posedge clk);

    test_reset_ident();
    test_write_readback();
    test_bit_ops();
    test_hw_status();
    test_malformed();

    $display("tests: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/hk_top.sv */
// housekeeping top level
// spi slave, decoder, control register bank and readback selector

`timescale 1ns/1ps
`default_nettype none

`include "hk_defines.svh"

module hk_top (
  input  wire logic                           clk,
  input  wire logic                           arst_n,
  input  wire logic                           sck,
  input  wire logic                           ss,
  input  wire logic                           sdi,
  output logic                                sdo,
  output logic [2:0]                          led,
  output logic [7:0]                          mon,
  input  wire logic [hk_regmap_pkg::HW_W-1:0] hw
);

  //////////////////////////////////////////////////////////////////////
  // spi side
  //////////////////////////////////////////////////////////////////////

  logic                  cmd_valid;
  hk_regmap_pkg::addr_e  cmd_addr;
  logic                  frame_valid;
  spi_frame_pkg::op_e    frame_op;
  hk_regmap_pkg::addr_e  frame_addr;
  logic [`HK_DATA_W-1:0] frame_data;
  logic [`HK_DATA_W-1:0] rd_data;

  spi_slave spi_slave_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .sck         (sck),
    .ss          (ss),
    .sdi         (sdi),
    .sdo         (sdo),
    .rd_data     (rd_data),
    .cmd_valid   (cmd_valid),
    .cmd_op      (),
    .cmd_addr    (cmd_addr),
    .frame_valid (frame_valid),
    .frame_op    (frame_op),
    .frame_addr  (frame_addr),
    .frame_data  (frame_data)
  );

  //////////////////////////////////////////////////////////////////////
  // register bank
  //////////////////////////////////////////////////////////////////////

  logic [`HK_NUM_CTRL-1:0] wr_en;
  spi_frame_pkg::op_e      wr_op;
  logic [`HK_DATA_W-1:0]   wr_data;
  logic [`HK_DATA_W-1:0]   ctrl_q [`HK_NUM_CTRL];

  reg_decode reg_decode_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .frame_valid (frame_valid),
    .frame_op    (frame_op),
    .frame_addr  (frame_addr),
    .frame_data  (frame_data),
    .wr_en       (wr_en),
    .wr_op       (wr_op),
    .wr_data     (wr_data)
  );

  // one register per writable address
  for (genvar i = 0; i < `HK_NUM_CTRL; i++) begin : g_ctrl
    ctrl_reg ctrl_reg_i (
      .clk     (clk),
      .arst_n  (arst_n),
      .wr_en   (wr_en[i]),
      .wr_op   (wr_op),
      .wr_data (wr_data),
      .q       (ctrl_q[i])
    );
  end

  // readback latched on the command byte before any update
  readback_sel readback_sel_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .hw        (hw),
    .cmd_valid (cmd_valid),
    .cmd_addr  (cmd_addr),
    .ctrl_q    (ctrl_q),
    .rd_data   (rd_data)
  );

  // pins take the low bits of led and mon
  assign led = ctrl_q[0][2:0];
  assign mon = ctrl_q[1][7:0];

endmodule

`default_nettype wire

/* hdl/readback_sel.sv */
// readback selector
// syncs the hw flags and latches the addressed word for the spi slave

`timescale 1ns/1ps
`default_nettype none

`include "hk_defines.svh"

module readback_sel (
  input  wire logic                         clk,
  input  wire logic                         arst_n,
  input  wire logic [hk_regmap_pkg::HW_W-1:0] hw,
  input  wire logic                         cmd_valid,
  input  wire hk_regmap_pkg::addr_e         cmd_addr,
  input  wire logic [`HK_DATA_W-1:0]        ctrl_q [`HK_NUM_CTRL],
  output logic [`HK_DATA_W-1:0]             rd_data
);

  // two flop synchronizer for the asynchronous pins
  logic [hk_regmap_pkg::HW_W-1:0] hw_meta;
  logic [hk_regmap_pkg::HW_W-1:0] hw_sync;
  logic [`HK_DATA_W-1:0]          status;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      hw_meta <= '0;
      hw_sync <= '0;
    end else begin
      hw_meta <= hw;
      hw_sync <= hw_meta;
    end
  end

  // flags in the low bits with zeros above
  assign status = {{(`HK_DATA_W - hk_regmap_pkg::HW_W){1'b0}}, hw_sync};

  // value before the frame touches anything
  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      case (cmd_addr)
        hk_regmap_pkg::ADDR_LED:     rd_data <= ctrl_q[0];
        hk_regmap_pkg::ADDR_MON:     rd_data <= ctrl_q[1];
        hk_regmap_pkg::ADDR_SCRATCH: rd_data <= ctrl_q[2];
        hk_regmap_pkg::ADDR_STATUS:  rd_data <= status;
        hk_regmap_pkg::ADDR_IDENT:   rd_data <= `HK_IDENT;
        default:                     rd_data <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/ctrl_reg.sv */
// one control register
// write, set, clear or toggle bits under a one cycle strobe

`timescale 1ns/1ps
`default_nettype none

`include "hk_defines.svh"

module ctrl_reg (
  input  wire logic                  clk,
  input  wire logic                  arst_n,
  input  wire logic                  wr_en,
  input  wire spi_frame_pkg::op_e    wr_op,
  input  wire logic [`HK_DATA_W-1:0] wr_data,
  output logic [`HK_DATA_W-1:0]      q
);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      // outputs come up low
      q <= '0;
    end else if (wr_en) begin
      case (wr_op)
        spi_frame_pkg::OP_WRITE:  q <= wr_data;
        // data acts as a bit mask for the rest
        spi_frame_pkg::OP_SET:    q <= q | wr_data;
        spi_frame_pkg::OP_CLEAR:  q <= q & ~wr_data;
        spi_frame_pkg::OP_TOGGLE: q <= q ^ wr_data;
        default:                  q <= q;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/reg_decode.sv */
// frame decoder
// turns a finished frame into one write strobe per control register

`timescale 1ns/1ps
`default_nettype none

`include "hk_defines.svh"

module reg_decode (
  input  wire logic                  clk,
  input  wire logic                  arst_n,
  input  wire logic                  frame_valid,
  input  wire spi_frame_pkg::op_e    frame_op,
  input  wire hk_regmap_pkg::addr_e  frame_addr,
  input  wire logic [`HK_DATA_W-1:0] frame_data,
  output logic [`HK_NUM_CTRL-1:0]    wr_en,
  output spi_frame_pkg::op_e         wr_op,
  output logic [`HK_DATA_W-1:0]      wr_data
);

  hk_regmap_pkg::ctrl_idx_t idx;
  logic                     addr_hit;
  logic                     op_mod;

  // only writable addresses hit and status and ident fall through
  always_comb begin
    idx      = '0;
    addr_hit = 1'b0;
    case (frame_addr)
      hk_regmap_pkg::ADDR_LED:     begin idx = 2'd0; addr_hit = 1'b1; end
      hk_regmap_pkg::ADDR_MON:     begin idx = 2'd1; addr_hit = 1'b1; end
      hk_regmap_pkg::ADDR_SCRATCH: begin idx = 2'd2; addr_hit = 1'b1; end
      default:                     addr_hit = 1'b0;
    endcase
  end

  // reads and unknown codes leave the registers alone
  assign op_mod = (frame_op == spi_frame_pkg::OP_WRITE) ||
                  (frame_op == spi_frame_pkg::OP_SET)   ||
                  (frame_op == spi_frame_pkg::OP_CLEAR) ||
                  (frame_op == spi_frame_pkg::OP_TOGGLE);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_en <= '0;
    end else begin
      wr_en <= '0;
      if (frame_valid && addr_hit && op_mod)
        wr_en[idx] <= 1'b1;
    end
  end

  // payload follows the strobe
  always_ff @(posedge clk) begin
    if (frame_valid) begin
      wr_op   <= frame_op;
      wr_data <= frame_data;
    end
  end

endmodule

`default_nettype wire

/* hdl/spi_slave.sv */
// spi mode 0 slave, oversampled in the clk domain
// shifts 40 bit frames in, readback word out, strobes command and frame

`timescale 1ns/1ps
`default_nettype none

`include "hk_defines.svh"

module spi_slave (
  input  wire logic                       clk,
  input  wire logic                       arst_n,
  input  wire logic                       sck,
  input  wire logic                       ss,
  input  wire logic                       sdi,
  output logic                            sdo,
  input  wire logic [`HK_DATA_W-1:0]      rd_data,
  output logic                            cmd_valid,
  output spi_frame_pkg::op_e              cmd_op,
  output hk_regmap_pkg::addr_e            cmd_addr,
  output logic                            frame_valid,
  output spi_frame_pkg::op_e              frame_op,
  output hk_regmap_pkg::addr_e            frame_addr,
  output logic [`HK_DATA_W-1:0]           frame_data
);

  localparam int CNT_W = $clog2(`HK_FRAME_BITS + 1);

  //////////////////////////////////////////////////////////////////////
  // pin synchronizers and edge detect
  //////////////////////////////////////////////////////////////////////

  // [0] first flop, [1] synchronized, [2] previous for edges
  logic [2:0] sck_q;
  logic [2:0] ss_q;
  logic [1:0] sdi_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      // idle levels for mode 0, ss deasserted
      sck_q <= 3'b000;
      ss_q  <= 3'b111;
      sdi_q <= 2'b00;
    end else begin
      sck_q <= {sck_q[1:0], sck};
      ss_q  <= {ss_q[1:0], ss};
      sdi_q <= {sdi_q[0], sdi};
    end
  end

  logic sck_rise;
  logic sck_fall;
  logic ss_s;
  logic ss_rise;

  assign sck_rise = sck_q[1] & ~sck_q[2];
  assign sck_fall = ~sck_q[1] & sck_q[2];
  assign ss_s     = ss_q[1];
  assign ss_rise  = ss_q[1] & ~ss_q[2];

  //////////////////////////////////////////////////////////////////////
  // receive side
  //////////////////////////////////////////////////////////////////////

  logic [CNT_W-1:0]          bit_cnt;
  logic [`HK_FRAME_BITS-1:0] shift_in;
  logic                      cmd_hit;
  logic                      cmd_valid_d;
  spi_frame_pkg::cmd_t       cmd_next;
  spi_frame_pkg::cmd_t       frame_cmd;

  // eighth bit being sampled right now
  assign cmd_hit  = ~ss_s & sck_rise & (bit_cnt == CNT_W'(spi_frame_pkg::CMD_BITS - 1));
  assign cmd_next = {shift_in[spi_frame_pkg::CMD_BITS-2:0], sdi_q[1]};
  // after a full frame the command byte sits at the top
  assign frame_cmd = shift_in[`HK_FRAME_BITS-1 -: spi_frame_pkg::CMD_BITS];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt     <= '0;
      cmd_valid   <= 1'b0;
      cmd_valid_d <= 1'b0;
      frame_valid <= 1'b0;
    end else begin
      cmd_valid   <= cmd_hit;
      cmd_valid_d <= cmd_valid;
      // short or long frames die here
      frame_valid <= ss_rise & (bit_cnt == CNT_W'(`HK_FRAME_BITS));
      if (ss_s)
        bit_cnt <= '0;
      else if (sck_rise && bit_cnt != '1)
        // saturate so an overlong frame never wraps back to 40
        bit_cnt <= bit_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (~ss_s && sck_rise)
      shift_in <= {shift_in[`HK_FRAME_BITS-2:0], sdi_q[1]};
    if (cmd_hit) begin
      cmd_op   <= cmd_next.op;
      cmd_addr <= hk_regmap_pkg::addr_e'(cmd_next.addr);
    end
    if (ss_rise) begin
      frame_op   <= frame_cmd.op;
      frame_addr <= hk_regmap_pkg::addr_e'(frame_cmd.addr);
      frame_data <= shift_in[`HK_DATA_W-1:0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // transmit side
  //////////////////////////////////////////////////////////////////////

  logic [`HK_DATA_W-1:0] shift_out;

  // readback word is ready one cycle after cmd_valid
  // the next falling edge puts its msb on sdo
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      shift_out <= '0;
      sdo       <= 1'b0;
    end else if (ss_s) begin
      shift_out <= '0;
      sdo       <= 1'b0;
    end else if (cmd_valid_d) begin
      shift_out <= rd_data;
    end else if (sck_fall) begin
      sdo       <= shift_out[`HK_DATA_W-1];
      shift_out <= {shift_out[`HK_DATA_W-2:0], 1'b0};
    end
  end

endmodule

`default_nettype wire

/* hdl/hk_regmap_pkg.sv */
// housekeeping register map
// register addresses, control register index, status field width

`default_nettype none

package hk_regmap_pkg;

  // number of hw flag inputs held in the status word
  localparam int HW_W = 3;

  // lower nibble of the command byte
  // addresses past ident read as zero and drop writes
  typedef enum logic [3:0] {
    ADDR_LED     = 4'd0,
    ADDR_MON     = 4'd1,
    ADDR_SCRATCH = 4'd2,
    // read only, synchronized hw flags
    ADDR_STATUS  = 4'd3,
    // read only constant
    ADDR_IDENT   = 4'd4
  } addr_e;

  // selects one of the writable registers
  typedef logic [1:0] ctrl_idx_t;

endpackage

`default_nettype wire

/* hdl/spi_frame_pkg.sv */
// spi frame fields
// operation codes and the layout of the command byte

`default_nettype none

package spi_frame_pkg;

  // width of the command byte at the head of each frame
  localparam int CMD_BITS = 8;

  // upper nibble of the command byte
  // unlisted codes fall back to a plain read
  typedef enum logic [3:0] {
    OP_READ   = 4'd0,
    OP_WRITE  = 4'd1,
    OP_SET    = 4'd2,
    OP_CLEAR  = 4'd3,
    OP_TOGGLE = 4'd4
  } op_e;

  // first byte on the wire, op goes out first
  typedef struct packed {
    op_e        op;
    logic [3:0] addr;
  } cmd_t;

endpackage

`default_nettype wire

/* hdl/hk_defines.svh */
// housekeeping block shared constants
// register width, spi frame length, control register count, ident word

`ifndef HK_DEFINES_SVH
`define HK_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// datapath
//////////////////////////////////////////////////////////////////////

// every register carries one word of this width
`define HK_DATA_W 32

// command byte plus data word
`define HK_FRAME_BITS 40

//////////////////////////////////////////////////////////////////////
// register file
//////////////////////////////////////////////////////////////////////

// led, mon, scratch
`define HK_NUM_CTRL 3

// "HK" then revision 1, read back at the ident address
`define HK_IDENT 32'h484b_0001

`endif
